// File: rdma_retrans_mux.f
+incdir+sim
rtl/rdma_stream_pkg.sv
rtl/rdma_req_pkg.sv
rtl/axis_beat_if.sv
rtl/route_seq_if.sv
rtl/stream_fifo.sv
rtl/req_router.sv
rtl/beat_mux.sv
rtl/rdma_retrans_mux.sv
sim/tb_rdma_retrans_mux.sv

// File: Bender.yml
package:
  name: rdma_retrans_mux

sources:
  - rtl/rdma_stream_pkg.sv
  - rtl/rdma_req_pkg.sv
  - rtl/axis_beat_if.sv
  - rtl/route_seq_if.sv
  - rtl/stream_fifo.sv
  - rtl/req_router.sv
  - rtl/beat_mux.sv
  - rtl/rdma_retrans_mux.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_rdma_retrans_mux.sv

// File: sim/tb_ref.svh
// Reference model for the retransmission multiplexer testbench.
// Included in the testbench module body. Works on the raw 52-bit request.

`ifndef TB_REF_SVH
`define TB_REF_SVH

// Route classes as seen by the testbench
localparam int RT_RD = 0;
localparam int RT_WR = 1;
localparam int RT_RE = 2;

// Request bits: opcode 51:47, actv 46, vfid 45:42, pid 41:36, offs 35:32, len 31:0
function automatic int ref_route(input logic [51:0] req);
  // Inactive request is a replay from memory
  if (!req[46]) begin
    return RT_RE;
  end
  if (req[51:47] >= 5'd13 && req[51:47] <= 5'd16) begin
    return RT_RD;
  end
  return RT_WR;
endfunction

// Address from vfid, pid and offset, then the memory shift, length in the low 16 bits
function automatic logic [63:0] ref_mem_cmd(input logic [51:0] req);
  logic [63:0] slot;
  logic [47:0] addr;
  slot = ({60'd0, req[45:42]} << 22) | ({58'd0, req[41:36]} << 16)
       | ({60'd0, req[35:32]} << 12);
  addr = slot[39:0] << 8;
  return {addr, req[15:0]};
endfunction

// Whole beats of 8 bytes, rounded up
function automatic int ref_beats(input int len);
  return (len + 7) / 8;
endfunction

// Byte enables of beat idx, partial only on the last one
function automatic logic [7:0] ref_keep(input int len, input int idx);
  int rem;
  rem = len - 8 * idx;
  if (rem >= 8) begin
    return 8'hff;
  end
  return (8'h01 << rem) - 8'h01;
endfunction

`endif

// File: sim/tb_rdma_retrans_mux.sv
// Testbench for the RDMA retransmission multiplexer.
// Runs directed read response, write and retransmission tests, a random mix,
// a queued burst and a reset check. Compares against the model in tb_ref.svh.

`timescale 1ns/1ps
`default_nettype none

module tb_rdma_retrans_mux;
  `include "tb_ref.svh"

  logic        aclk;
  logic        aresetn;
  logic        s_req_valid;
  logic        s_req_ready;
  logic [51:0] s_req_data;
  logic        m_req_user_valid;
  logic        m_req_user_ready;
  logic [51:0] m_req_user_data;
  logic        m_req_ddr_rd_valid;
  logic        m_req_ddr_rd_ready;
  logic [63:0] m_req_ddr_rd_data;
  logic        m_req_ddr_wr_valid;
  logic        m_req_ddr_wr_ready;
  logic [63:0] m_req_ddr_wr_data;
  logic        s_user_req_tvalid;
  logic        s_user_req_tready;
  logic [63:0] s_user_req_tdata;
  logic [7:0]  s_user_req_tkeep;
  logic        s_user_req_tlast;
  logic        s_user_rsp_tvalid;
  logic        s_user_rsp_tready;
  logic [63:0] s_user_rsp_tdata;
  logic [7:0]  s_user_rsp_tkeep;
  logic        s_user_rsp_tlast;
  logic        s_ddr_tvalid;
  logic        s_ddr_tready;
  logic [63:0] s_ddr_tdata;
  logic [7:0]  s_ddr_tkeep;
  logic        s_ddr_tlast;
  logic        m_net_tvalid;
  logic        m_net_tready;
  logic [63:0] m_net_tdata;
  logic [7:0]  m_net_tkeep;
  logic        m_net_tlast;
  logic        m_ddr_tvalid;
  logic        m_ddr_tready;
  logic [63:0] m_ddr_tdata;
  logic [7:0]  m_ddr_tkeep;
  logic        m_ddr_tlast;

  // Expected traffic per output port with beats packed as data, keep and last
  logic [51:0] exp_user_q[$];
  logic [63:0] exp_rd_q[$];
  logic [63:0] exp_wr_q[$];
  logic [72:0] exp_net_q[$];
  logic [72:0] exp_ddr_q[$];
  // Beats waiting at each data source
  logic [72:0] src_req_q[$];
  logic [72:0] src_rsp_q[$];
  logic [72:0] src_ddr_q[$];
  logic [51:0] batch [10];

  bit    req_hold;
  bit    rsp_hold;
  bit    ddr_hold;
  bit    src_enable;
  bit    rand_out;
  bit    rand_cmd;
  int    errors;
  int    checks;
  int    tests;
  int    cycles;
  int    gen_beats;
  int    accepted;
  string test_name;

  rdma_retrans_mux rdma_retrans_mux_i (.*);

  always #2 aclk = ~aclk;

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  function automatic logic [51:0] make_req(input logic [4:0] op, input logic actv,
                                           input logic [3:0] vfid, input logic [5:0] pid,
                                           input logic [3:0] offs, input int len);
    return {op, actv, vfid, pid, offs, len[31:0]};
  endfunction

  // Loads the command and all beats of one request into the expected queues
  task automatic queue_req(input logic [51:0] req);
    int          len;
    int          route;
    int          n;
    logic [72:0] beat;
    len   = int'(req[31:0]);
    route = ref_route(req);
    n     = ref_beats(len);
    gen_beats += n;
    case (route)
      RT_RD:   exp_user_q.push_back(req);
      RT_WR:   exp_wr_q.push_back(ref_mem_cmd(req));
      default: exp_rd_q.push_back(ref_mem_cmd(req));
    endcase
    for (int i = 0; i < n; i++) begin
      beat = {$urandom, $urandom, ref_keep(len, i), i == n - 1};
      exp_net_q.push_back(beat);
      if (route == RT_RD) begin
        src_rsp_q.push_back(beat);
      end else if (route == RT_WR) begin
        src_req_q.push_back(beat);
        exp_ddr_q.push_back(beat);
      end else begin
        src_ddr_q.push_back(beat);
      end
    end
  endtask

  // Holds the request until the DUT takes it
  task automatic send_req(input logic [51:0] req);
    @(negedge aclk);
    s_req_valid = 1'b1;
    s_req_data  = req;
    @(posedge aclk);
    while (!s_req_ready) begin
      @(posedge aclk);
    end
    @(negedge aclk);
    s_req_valid = 1'b0;
  endtask

  task automatic end_test(input int err_before);
    while (exp_user_q.size() + exp_rd_q.size() + exp_wr_q.size()
           + exp_net_q.size() + exp_ddr_q.size() != 0) begin
      @(posedge aclk);
    end
    // Room for stray beats to show up
    repeat (8) @(posedge aclk);
    tests++;
    $display("Test %-8s done with %0d errors", test_name, errors - err_before);
  endtask

  // --------------------------------------------------
  // Compare process that pops once per output handshake
  // --------------------------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      if (m_req_user_valid && m_req_user_ready) begin
        if (exp_user_q.size() == 0) report_error("unexpected request on the user port");
        else check("user request", exp_user_q.pop_front(), m_req_user_data);
      end
      if (m_req_ddr_rd_valid && m_req_ddr_rd_ready) begin
        if (exp_rd_q.size() == 0) report_error("unexpected memory read command");
        else check("memory read command", exp_rd_q.pop_front(), m_req_ddr_rd_data);
      end
      if (m_req_ddr_wr_valid && m_req_ddr_wr_ready) begin
        if (exp_wr_q.size() == 0) report_error("unexpected memory write command");
        else check("memory write command", exp_wr_q.pop_front(), m_req_ddr_wr_data);
      end
      if (m_net_tvalid && m_net_tready) begin
        if (exp_net_q.size() == 0) report_error("unexpected beat on the network output");
        else check("network beat", exp_net_q.pop_front(), {m_net_tdata, m_net_tkeep, m_net_tlast});
      end
      if (m_ddr_tvalid && m_ddr_tready) begin
        if (exp_ddr_q.size() == 0) report_error("unexpected beat on the memory output");
        else check("memory beat", exp_ddr_q.pop_front(), {m_ddr_tdata, m_ddr_tkeep, m_ddr_tlast});
      end
    end
  end

  // Source side bookkeeping
  always @(posedge aclk) begin
    if (s_req_valid && s_req_ready) accepted++;
    if (s_user_req_tvalid && s_user_req_tready) begin
      void'(src_req_q.pop_front());
      req_hold = 1'b0;
    end
    if (s_user_rsp_tvalid && s_user_rsp_tready) begin
      void'(src_rsp_q.pop_front());
      rsp_hold = 1'b0;
    end
    if (s_ddr_tvalid && s_ddr_tready) begin
      void'(src_ddr_q.pop_front());
      ddr_hold = 1'b0;
    end
  end

  // Limit grows with the beats generated so far
  always @(posedge aclk) begin
    cycles++;
    if (cycles > 1000 + 8 * gen_beats) begin
      $display("Timeout: the run was still busy after %0d cycles", cycles - 1);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Falling edge drivers with random gaps and ready
  // --------------------------------------------------
  always @(negedge aclk) begin
    if (aresetn) begin
      m_net_tready       = rand_out ? (($urandom % 4) != 0) : 1'b1;
      m_ddr_tready       = rand_out ? (($urandom % 4) != 0) : 1'b1;
      m_req_user_ready   = rand_cmd ? (($urandom % 2) != 0) : 1'b1;
      m_req_ddr_rd_ready = rand_cmd ? (($urandom % 2) != 0) : 1'b1;
      m_req_ddr_wr_ready = rand_cmd ? (($urandom % 2) != 0) : 1'b1;
      // A presented beat stays until it moves
      if (!req_hold) begin
        s_user_req_tvalid = 1'b0;
        if (src_enable && src_req_q.size() > 0 && ($urandom % 4) != 0) begin
          {s_user_req_tdata, s_user_req_tkeep, s_user_req_tlast} = src_req_q[0];
          s_user_req_tvalid = 1'b1;
          req_hold = 1'b1;
        end
      end
      if (!rsp_hold) begin
        s_user_rsp_tvalid = 1'b0;
        if (src_enable && src_rsp_q.size() > 0 && ($urandom % 4) != 0) begin
          {s_user_rsp_tdata, s_user_rsp_tkeep, s_user_rsp_tlast} = src_rsp_q[0];
          s_user_rsp_tvalid = 1'b1;
          rsp_hold = 1'b1;
        end
      end
      if (!ddr_hold) begin
        s_ddr_tvalid = 1'b0;
        if (src_enable && src_ddr_q.size() > 0 && ($urandom % 4) != 0) begin
          {s_ddr_tdata, s_ddr_tkeep, s_ddr_tlast} = src_ddr_q[0];
          s_ddr_tvalid = 1'b1;
          ddr_hold = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int          e0;
    int          acc0;
    int          r;
    logic [51:0] req;
    void'($urandom(32'h742d5934));
    aclk = 1'b0;
    aresetn = 1'b0;
    s_req_valid = 1'b0;
    s_req_data = '0;
    m_req_user_ready = 1'b0;
    m_req_ddr_rd_ready = 1'b0;
    m_req_ddr_wr_ready = 1'b0;
    {s_user_req_tvalid, s_user_req_tdata, s_user_req_tkeep, s_user_req_tlast} = '0;
    {s_user_rsp_tvalid, s_user_rsp_tdata, s_user_rsp_tkeep, s_user_rsp_tlast} = '0;
    {s_ddr_tvalid, s_ddr_tdata, s_ddr_tkeep, s_ddr_tlast} = '0;
    m_net_tready = 1'b0;
    m_ddr_tready = 1'b0;
    src_enable = 1'b1;
    rand_out = 1'b0;
    rand_cmd = 1'b0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Idle outputs and no source drained
    test_name = "reset";
    e0 = errors;
    repeat (2) @(posedge aclk);
    check("output valids", '0, {m_req_user_valid, m_req_ddr_rd_valid, m_req_ddr_wr_valid,
                                m_net_tvalid, m_ddr_tvalid});
    check("source readies", '0, {s_user_req_tready, s_user_rsp_tready, s_ddr_tready});
    end_test(e0);

    test_name = "rd_rsp";
    e0 = errors;
    req = make_req(5'd14, 1'b1, 4'd3, 6'd17, 4'd5, 40);
    queue_req(req);
    send_req(req);
    req = make_req(5'd16, 1'b1, 4'd1, 6'd2, 4'd0, 9);
    queue_req(req);
    send_req(req);
    end_test(e0);

    test_name = "write";
    e0 = errors;
    req = make_req(5'd4, 1'b1, 4'd9, 6'd33, 4'd7, 24);
    queue_req(req);
    send_req(req);
    req = make_req(5'd12, 1'b1, 4'd2, 6'd5, 4'd1, 61);
    queue_req(req);
    send_req(req);
    end_test(e0);

    test_name = "retrans";
    e0 = errors;
    req = make_req(5'd10, 1'b0, 4'd15, 6'd63, 4'd15, 64);
    queue_req(req);
    send_req(req);
    req = make_req(5'd14, 1'b0, 4'd6, 6'd20, 4'd3, 1);
    queue_req(req);
    send_req(req);
    end_test(e0);

    // Random routes and lengths 1 to 64 with random ready on all outputs
    test_name = "mixed";
    e0 = errors;
    rand_out = 1'b1;
    rand_cmd = 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = $urandom % 3;
      if (r == RT_RD) req = make_req(5'(13 + $urandom % 4), 1'b1, 4'($urandom), 6'($urandom),
                                     4'($urandom), 1 + $urandom % 64);
      else if (r == RT_WR) req = make_req(5'($urandom % 13), 1'b1, 4'($urandom), 6'($urandom),
                                          4'($urandom), 1 + $urandom % 64);
      else req = make_req(5'($urandom), 1'b0, 4'($urandom), 6'($urandom),
                          4'($urandom), 1 + $urandom % 64);
      queue_req(req);
      send_req(req);
    end
    end_test(e0);

    // Sources held back until the route queue blocks new requests
    test_name = "queued";
    e0 = errors;
    rand_out = 1'b0;
    rand_cmd = 1'b0;
    src_enable = 1'b0;
    acc0 = accepted;
    for (int i = 0; i < 10; i++) begin
      batch[i] = make_req((i % 3 == 2) ? 5'd13 : 5'd3, i % 3 != 1, 4'(i), 6'(i), 4'(i), 16);
      queue_req(batch[i]);
    end
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_req(batch[i]);
        end
      end
    join_none
    while (!(s_req_valid && !s_req_ready)) begin
      @(posedge aclk);
    end
    // Eight entries fill the route queue while one more sits in the data mux
    check("accepted before stall", 9, accepted - acc0);
    @(negedge aclk);
    src_enable = 1'b1;
    end_test(e0);
    wait fork;

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/rdma_retrans_mux.sv
// Top level of the RDMA retransmission multiplexer.
// Sits between the network stack request/data ports and the user and memory
// sides of the RoCE stack. Plain valid/ready ports only.

`timescale 1ns/1ps
`default_nettype none

module rdma_retrans_mux (
  input  logic aclk,
  input  logic aresetn,
  // Requests from the network stack
  input  logic                                       s_req_valid,
  output logic                                       s_req_ready,
  input  logic [rdma_req_pkg::REQ_BITS-1:0]          s_req_data,
  // Command ports
  output logic                                       m_req_user_valid,
  input  logic                                       m_req_user_ready,
  output logic [rdma_req_pkg::REQ_BITS-1:0]          m_req_user_data,
  output logic                                       m_req_ddr_rd_valid,
  input  logic                                       m_req_ddr_rd_ready,
  output logic [$bits(rdma_req_pkg::mem_cmd_t)-1:0]  m_req_ddr_rd_data,
  output logic                                       m_req_ddr_wr_valid,
  input  logic                                       m_req_ddr_wr_ready,
  output logic [$bits(rdma_req_pkg::mem_cmd_t)-1:0]  m_req_ddr_wr_data,
  // Data sources
  input  logic                                       s_user_req_tvalid,
  output logic                                       s_user_req_tready,
  input  logic [rdma_stream_pkg::BEAT_BITS-1:0]      s_user_req_tdata,
  input  logic [rdma_stream_pkg::BEAT_BYTES-1:0]     s_user_req_tkeep,
  input  logic                                       s_user_req_tlast,
  input  logic                                       s_user_rsp_tvalid,
  output logic                                       s_user_rsp_tready,
  input  logic [rdma_stream_pkg::BEAT_BITS-1:0]      s_user_rsp_tdata,
  input  logic [rdma_stream_pkg::BEAT_BYTES-1:0]     s_user_rsp_tkeep,
  input  logic                                       s_user_rsp_tlast,
  input  logic                                       s_ddr_tvalid,
  output logic                                       s_ddr_tready,
  input  logic [rdma_stream_pkg::BEAT_BITS-1:0]      s_ddr_tdata,
  input  logic [rdma_stream_pkg::BEAT_BYTES-1:0]     s_ddr_tkeep,
  input  logic                                       s_ddr_tlast,
  // Data outputs
  output logic                                       m_net_tvalid,
  input  logic                                       m_net_tready,
  output logic [rdma_stream_pkg::BEAT_BITS-1:0]      m_net_tdata,
  output logic [rdma_stream_pkg::BEAT_BYTES-1:0]     m_net_tkeep,
  output logic                                       m_net_tlast,
  output logic                                       m_ddr_tvalid,
  input  logic                                       m_ddr_tready,
  output logic [rdma_stream_pkg::BEAT_BITS-1:0]      m_ddr_tdata,
  output logic [rdma_stream_pkg::BEAT_BYTES-1:0]     m_ddr_tkeep,
  output logic                                       m_ddr_tlast
);
  import rdma_req_pkg::*;
  import rdma_stream_pkg::*;

  route_seq_if seq_in ();
  route_seq_if seq_q ();
  axis_beat_if user_req ();
  axis_beat_if user_rsp ();
  axis_beat_if ddr_in ();
  axis_beat_if net_beat ();
  axis_beat_if ddr_beat ();

  mem_cmd_t                           ddr_cmd;
  logic [$bits(route_t)+LEN_BITS-1:0] seq_q_data;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------
  req_router router_i (
    .req_valid    (s_req_valid),
    .req_ready    (s_req_ready),
    .req_data     (s_req_data),
    .user_valid   (m_req_user_valid),
    .user_ready   (m_req_user_ready),
    .user_data    (m_req_user_data),
    .ddr_rd_valid (m_req_ddr_rd_valid),
    .ddr_rd_ready (m_req_ddr_rd_ready),
    .ddr_wr_valid (m_req_ddr_wr_valid),
    .ddr_wr_ready (m_req_ddr_wr_ready),
    .ddr_cmd      (ddr_cmd),
    .seq          (seq_in)
  );

  // One command word, qualified per port by its valid
  assign m_req_ddr_rd_data = ddr_cmd;
  assign m_req_ddr_wr_data = ddr_cmd;

  // Route queue keeps request order for the data side
  stream_fifo #(.WIDTH($bits(route_t) + LEN_BITS), .DEPTH(SEQ_DEPTH)) seq_fifo_i (
    .aclk,
    .aresetn,
    .wr_valid (seq_in.valid),
    .wr_ready (seq_in.ready),
    .wr_data  ({seq_in.route, seq_in.len}),
    .rd_valid (seq_q.valid),
    .rd_ready (seq_q.ready),
    .rd_data  (seq_q_data)
  );

  assign seq_q.route = route_t'(seq_q_data[LEN_BITS +: $bits(route_t)]);
  assign seq_q.len   = seq_q_data[LEN_BITS-1:0];

  // --------------------------------------------------
  // Data side
  // --------------------------------------------------
  assign user_req.tvalid   = s_user_req_tvalid;
  assign user_req.tdata    = s_user_req_tdata;
  assign user_req.tkeep    = s_user_req_tkeep;
  assign user_req.tlast    = s_user_req_tlast;
  assign s_user_req_tready = user_req.tready;

  assign user_rsp.tvalid   = s_user_rsp_tvalid;
  assign user_rsp.tdata    = s_user_rsp_tdata;
  assign user_rsp.tkeep    = s_user_rsp_tkeep;
  assign user_rsp.tlast    = s_user_rsp_tlast;
  assign s_user_rsp_tready = user_rsp.tready;

  assign ddr_in.tvalid = s_ddr_tvalid;
  assign ddr_in.tdata  = s_ddr_tdata;
  assign ddr_in.tkeep  = s_ddr_tkeep;
  assign ddr_in.tlast  = s_ddr_tlast;
  assign s_ddr_tready  = ddr_in.tready;

  beat_mux beat_mux_i (
    .aclk,
    .aresetn,
    .seq      (seq_q),
    .user_req (user_req),
    .user_rsp (user_rsp),
    .ddr_in   (ddr_in),
    .net_out  (net_beat),
    .ddr_out  (ddr_beat)
  );

  // Output queues, beat packed as data, keep, last
  stream_fifo #(.WIDTH(BEAT_BITS + BEAT_BYTES + 1), .DEPTH(DATA_Q_DEPTH)) net_fifo_i (
    .aclk,
    .aresetn,
    .wr_valid (net_beat.tvalid),
    .wr_ready (net_beat.tready),
    .wr_data  ({net_beat.tdata, net_beat.tkeep, net_beat.tlast}),
    .rd_valid (m_net_tvalid),
    .rd_ready (m_net_tready),
    .rd_data  ({m_net_tdata, m_net_tkeep, m_net_tlast})
  );

  stream_fifo #(.WIDTH(BEAT_BITS + BEAT_BYTES + 1), .DEPTH(DATA_Q_DEPTH)) ddr_fifo_i (
    .aclk,
    .aresetn,
    .wr_valid (ddr_beat.tvalid),
    .wr_ready (ddr_beat.tready),
    .wr_data  ({ddr_beat.tdata, ddr_beat.tkeep, ddr_beat.tlast}),
    .rd_valid (m_ddr_tvalid),
    .rd_ready (m_ddr_tready),
    .rd_data  ({m_ddr_tdata, m_ddr_tkeep, m_ddr_tlast})
  );

endmodule

`default_nettype wire

// File: rtl/beat_mux.sv
// Data mux for the retransmission multiplexer.
// Takes one route queue entry per request, counts its beats and steers the
// selected source to the network queue, and on writes also to memory.

`timescale 1ns/1ps
`default_nettype none

module beat_mux (
  input  logic     aclk,
  input  logic     aresetn,
  route_seq_if.snk seq,
  axis_beat_if.snk user_req,
  axis_beat_if.snk user_rsp,
  axis_beat_if.snk ddr_in,
  axis_beat_if.src net_out,
  axis_beat_if.src ddr_out
);
  import rdma_req_pkg::*;
  import rdma_stream_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_MUX
  } state_t;

  state_t              state;
  state_t              state_next;
  route_t              cur_route;
  route_t              route_next;
  logic [CNT_BITS-1:0] cnt;
  logic [CNT_BITS-1:0] cnt_next;
  logic [CNT_BITS-1:0] cnt_load;
  logic [LEN_BITS-1:0] len_m1;
  logic                beat_fire;
  logic                last_beat;

  // Beats minus one, length rounded up to whole beats
  assign len_m1   = seq.len - LEN_BITS'(1);
  assign cnt_load = CNT_BITS'(len_m1[LEN_BITS-1:BEAT_LOG_BITS]);

  // Handshake on the selected source, zero while idle
  always_comb begin
    case (cur_route)
      ROUTE_RD_RSP: beat_fire = user_rsp.tvalid & user_rsp.tready;
      ROUTE_WR:     beat_fire = user_req.tvalid & user_req.tready;
      default:      beat_fire = ddr_in.tvalid & ddr_in.tready;
    endcase
  end

  assign last_beat = beat_fire & (cnt == '0);

  // Next entry taken while idle or together with the last beat
  assign seq.ready = (state == ST_IDLE) | last_beat;

  // --------------------------------------------------
  // FSM and beat counter
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    route_next = cur_route;
    cnt_next   = cnt;
    if (seq.valid && seq.ready) begin
      state_next = ST_MUX;
      route_next = seq.route;
      cnt_next   = cnt_load;
    end else if (last_beat) begin
      state_next = ST_IDLE;
    end else if (beat_fire) begin
      cnt_next = cnt - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= ST_IDLE;
      cur_route <= ROUTE_RD_RSP;
      cnt       <= '0;
    end else begin
      state     <= state_next;
      cur_route <= route_next;
      cnt       <= cnt_next;
    end
  end

  // --------------------------------------------------
  // Steering
  // --------------------------------------------------
  always_comb begin
    user_req.tready = 1'b0;
    user_rsp.tready = 1'b0;
    ddr_in.tready   = 1'b0;
    net_out.tvalid  = 1'b0;
    ddr_out.tvalid  = 1'b0;
    if (state == ST_MUX) begin
      case (cur_route)
        ROUTE_RD_RSP: begin
          user_rsp.tready = net_out.tready;
          net_out.tvalid  = user_rsp.tvalid;
        end
        ROUTE_WR: begin
          // Both queues take the beat in the same cycle or neither does
          user_req.tready = net_out.tready & ddr_out.tready;
          net_out.tvalid  = user_req.tvalid & ddr_out.tready;
          ddr_out.tvalid  = user_req.tvalid & net_out.tready;
        end
        default: begin
          ddr_in.tready  = net_out.tready;
          net_out.tvalid = ddr_in.tvalid;
        end
      endcase
    end
  end

  // Network payload follows the current route
  always_comb begin
    case (cur_route)
      ROUTE_RD_RSP: begin
        net_out.tdata = user_rsp.tdata;
        net_out.tkeep = user_rsp.tkeep;
        net_out.tlast = user_rsp.tlast;
      end
      ROUTE_WR: begin
        net_out.tdata = user_req.tdata;
        net_out.tkeep = user_req.tkeep;
        net_out.tlast = user_req.tlast;
      end
      default: begin
        net_out.tdata = ddr_in.tdata;
        net_out.tkeep = ddr_in.tkeep;
        net_out.tlast = ddr_in.tlast;
      end
    endcase
  end

  // Memory copy of the write payload
  assign ddr_out.tdata = user_req.tdata;
  assign ddr_out.tkeep = user_req.tkeep;
  assign ddr_out.tlast = user_req.tlast;

  // No source is drained between transfers
  a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    (state == ST_IDLE) |-> !(user_req.tready || user_rsp.tready || ddr_in.tready));

endmodule

`default_nettype wire

// File: rtl/req_router.sv
// Request classifier for the retransmission multiplexer.
// Sends each request to the user port or to one of the memory command ports,
// and records its route and length in the route queue in the same cycle.

`timescale 1ns/1ps
`default_nettype none

module req_router (
  input  logic                              req_valid,
  output logic                              req_ready,
  input  rdma_req_pkg::req_word_u           req_data,
  output logic                              user_valid,
  input  logic                              user_ready,
  output logic [rdma_req_pkg::REQ_BITS-1:0] user_data,
  output logic                              ddr_rd_valid,
  input  logic                              ddr_rd_ready,
  output logic                              ddr_wr_valid,
  input  logic                              ddr_wr_ready,
  output rdma_req_pkg::mem_cmd_t            ddr_cmd,
  route_seq_if.src                          seq
);
  import rdma_req_pkg::*;
  import rdma_stream_pkg::*;

  route_t               route;
  logic                 cmd_ready;
  logic [ADDR_BITS-1:0] base_addr;

  // --------------------------------------------------
  // Route decode
  // --------------------------------------------------
  always_comb begin
    if (!req_data.f.actv) begin
      // Inactive request means replay from memory
      route = ROUTE_RETRANS;
    end else if (is_rd_resp(req_data.f.opcode)) begin
      route = ROUTE_RD_RSP;
    end else begin
      route = ROUTE_WR;
    end
  end

  // Ready of the command port this request targets
  always_comb begin
    case (route)
      ROUTE_RD_RSP: cmd_ready = user_ready;
      ROUTE_WR:     cmd_ready = ddr_wr_ready;
      default:      cmd_ready = ddr_rd_ready;
    endcase
  end

  // Accept only when both the route queue and the command port can take it
  assign req_ready = seq.ready & cmd_ready;

  // Each side sees valid qualified by the other side's ready
  assign seq.valid    = req_valid & cmd_ready;
  assign user_valid   = req_valid & seq.ready & (route == ROUTE_RD_RSP);
  assign ddr_wr_valid = req_valid & seq.ready & (route == ROUTE_WR);
  assign ddr_rd_valid = req_valid & seq.ready & (route == ROUTE_RETRANS);

  assign seq.route = route;
  assign seq.len   = req_data.f.len[LEN_BITS-1:0];

  // --------------------------------------------------
  // Memory command
  // --------------------------------------------------
  // Slot address from vfid, pid and offset, one PMTU per slot
  assign base_addr = (ADDR_BITS'(req_data.f.vfid) << (PID_BITS + OST_BITS + PMTU_LOG))
                   | (ADDR_BITS'(req_data.f.pid) << (OST_BITS + PMTU_LOG))
                   | (ADDR_BITS'(req_data.f.offs) << PMTU_LOG);

  assign ddr_cmd.addr = base_addr << MEM_SHIFT;
  assign ddr_cmd.len  = req_data.f.len[LEN_BITS-1:0];

  // Read responses go out unchanged
  assign user_data = req_data.raw;

  // Only one command port is offered a request at a time
  always_comb begin
    a_one_cmd: assert final ($onehot0({user_valid, ddr_rd_valid, ddr_wr_valid}));
  end

endmodule

`default_nettype wire

// File: rtl/stream_fifo.sv
// Synchronous FIFO with valid/ready on both sides.
// Used as route queue and as the two data output queues.
// Write side ready is not-full, read side valid is not-empty.

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  logic [WIDTH-1:0] wr_data,
  output logic             rd_valid,
  input  logic             rd_ready,
  output logic [WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       wr_fire;
  logic                       rd_fire;

  // Flags straight from the fill count
  assign wr_ready = (32'(count) != DEPTH);
  assign rd_valid = (count != '0);
  assign wr_fire  = wr_valid & wr_ready;
  assign rd_fire  = rd_valid & rd_ready;

  // --------------------------------------------------
  // Pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH
      if (wr_fire) begin
        wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr];

  // Fill count stays in range across any mix of pushes and pops
  a_count_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    32'(count) <= DEPTH);

  // Head entry holds while the reader stalls
  a_rd_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_valid && !rd_ready |=> $stable(rd_data));

endmodule

`default_nettype wire

// File: rtl/route_seq_if.sv
// Route queue entry with valid/ready handshake.
// Carries the route and byte length of one accepted request.

`timescale 1ns/1ps
`default_nettype none

interface route_seq_if;
  import rdma_req_pkg::*;
  import rdma_stream_pkg::*;

  logic                valid;
  logic                ready;
  route_t              route;
  logic [LEN_BITS-1:0] len;

  modport src (output valid, route, len, input ready);
  modport snk (input valid, route, len, output ready);

endinterface

`default_nettype wire

// File: rtl/axis_beat_if.sv
// One data beat with valid/ready handshake.
// Links the data mux to the output queues.

`timescale 1ns/1ps
`default_nettype none

interface axis_beat_if;
  import rdma_stream_pkg::*;

  logic                  tvalid;
  logic                  tready;
  logic [BEAT_BITS-1:0]  tdata;
  logic [BEAT_BYTES-1:0] tkeep;
  // Carried along, never used for framing
  logic                  tlast;

  modport src (output tvalid, tdata, tkeep, tlast, input tready);
  modport snk (input tvalid, tdata, tkeep, tlast, output tready);

endinterface

`default_nettype wire

// File: rtl/rdma_req_pkg.sv
// Request word layout for the retransmission multiplexer.
// Covers the request fields, the route classes and the memory command
// format built from a request. Shared by the router, the data mux and the top.

`default_nettype none

package rdma_req_pkg;

  // --------------------------------------------------
  // Request field widths
  // --------------------------------------------------
  localparam int unsigned OPCODE_BITS  = 5;
  localparam int unsigned VFID_BITS    = 4;
  localparam int unsigned PID_BITS     = 6;
  localparam int unsigned OST_BITS     = 4;
  localparam int unsigned REQ_LEN_BITS = 32;
  localparam int unsigned REQ_BITS     = 52;

  // Address layout, one PMTU per outstanding slot
  localparam int unsigned PMTU_LOG  = 12;
  localparam int unsigned MEM_SHIFT = 8;
  localparam int unsigned ADDR_BITS = 48;

  // Read response opcode range
  localparam int unsigned RD_RSP_FIRST = 13;
  localparam int unsigned RD_RSP_LAST  = 16;

  typedef struct packed {
    logic [OPCODE_BITS-1:0]  opcode;
    logic                    actv;
    logic [VFID_BITS-1:0]    vfid;
    logic [PID_BITS-1:0]     pid;
    logic [OST_BITS-1:0]     offs;
    logic [REQ_LEN_BITS-1:0] len;
  } req_fields_t;

  // Decoded view for routing, raw view for the user port
  typedef union packed {
    req_fields_t         f;
    logic [REQ_BITS-1:0] raw;
  } req_word_u;

  typedef struct packed {
    logic [ADDR_BITS-1:0]               addr;
    logic [rdma_stream_pkg::LEN_BITS-1:0] len;
  } mem_cmd_t;

  typedef enum logic [1:0] {
    ROUTE_RD_RSP,
    ROUTE_WR,
    ROUTE_RETRANS
  } route_t;

  function automatic logic is_rd_resp(input logic [OPCODE_BITS-1:0] opcode);
    return (opcode >= OPCODE_BITS'(RD_RSP_FIRST)) && (opcode <= OPCODE_BITS'(RD_RSP_LAST));
  endfunction

endpackage

`default_nettype wire

// File: rtl/rdma_stream_pkg.sv
// Data path sizing for the retransmission multiplexer.
// Beat width, request length width and queue depths.

`default_nettype none

package rdma_stream_pkg;

  // One data beat
  localparam int unsigned BEAT_BITS     = 64;
  localparam int unsigned BEAT_BYTES    = 8;
  localparam int unsigned BEAT_LOG_BITS = 3;

  // Request length in bytes, as carried on the data side
  localparam int unsigned LEN_BITS = 16;

  // Queue depths
  localparam int unsigned SEQ_DEPTH    = 8;
  localparam int unsigned DATA_Q_DEPTH = 4;

  // Beats per request minus one, with one spare bit
  localparam int unsigned CNT_BITS = LEN_BITS - BEAT_LOG_BITS + 1;

endpackage

`default_nettype wire
